// File: sim.f
verilog/cps_mmr_pkg.sv
verilog/wb_ppu_port.sv
verilog/cpsa_regs.sv
verilog/cpsb_cfg_chain.sv
verilog/cpsb_regs.sv
verilog/cps_mmr_top.sv
verif/cps_mmr_asserts.sv
verif/cps_mmr_tb.sv

// File: Makefile
TOP := cps_mmr_tb

.PHONY: run lint clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

obj_dir/V$(TOP): sim.f verilog/*.sv verif/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

// File: verif/cps_mmr_vectors.txt
# op and hex fields: c bytes (first sent first), w adr sel data, r adr expected,
# x first last (random CPS-A writes), p pulses, b/s/l snapshot of bases/scroll/layer
b
s
l
r 00 ffff
r 11 ffff
x 00 04
p 0
x 05 05
p 1
x 06 11
p 0
b
s
c 30 08 04 02 2a 32 28 30 26 2e 12 10 0e 0c 42 20
l
r 30 0402
r 21 ffff
r 3f ffff
w 26 3 1234
w 27 3 5678
r 28 0060
r 29 0626
r 26 1234
w 37 3 0123
w 33 3 1111
w 38 3 2222
w 34 3 3333
w 39 3 4444
w 35 3 00ff
r 37 0123
r 33 1111
r 38 2222
r 34 3333
r 39 4444
r 35 003f
w 37 1 abcd
w 33 2 abcd
r 37 0123
r 33 1111
l
x 00 11
p 1
b
s

// File: verif/cps_mmr_tb.sv
/*
 * Testbench for the register block: clock and reset, vector file
 * reader, Wishbone tasks, reference model and compare tasks.
 */
`timescale 1ns/1ps

module cps_mmr_tb import cps_mmr_pkg::*; ();

    logic        clk;
    logic        reg_rst;
    logic        ppu_rstn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [6:1]  wb_adr;
    logic [1:0]  wb_sel;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic        cfg_we;
    logic [7:0]  cfg_data;
    vram_bases_t bases;
    scroll_pos_t scroll;
    layer_cfg_t  layer;
    logic        pal_copy;

    // reference model state
    logic [15:0] a_model [CPSA_NREGS];
    logic [7:0]  chain_model [CFG_BYTES];
    int          cfg_count;
    logic [15:0] layer_m;
    logic [15:0] prio_m [4];
    logic [5:0]  pal_page_m;
    logic [31:0] lfsr_state;
    int          pulse_count = 0;
    int          cycle_no = 0;
    int          pulse_cycle = 0;
    int          pal_drop_cycle = 0;

    cps_mmr_top u_cps_mmr_top (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu_rstn (ppu_rstn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .bases    (bases),
        .scroll   (scroll),
        .layer    (layer),
        .pal_copy (pal_copy)
    );

    always #50 clk = ~clk;

    // count the copy pulse cycles and note the edge the pulse rose on
    always @(posedge clk) begin
        cycle_no <= cycle_no + 1;
        if (pal_copy) begin
            pulse_count <= pulse_count + 1;
            pulse_cycle <= cycle_no;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input logic [15:0] exp, input logic [15:0] act, input string what);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %h got %h",
                                $time, what, exp, act));
        end
    endtask

    task automatic check_count(input int exp, input int act, input string what);
        if (act != exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %0d got %0d",
                                $time, what, exp, act));
        end
    endtask

    task automatic check_bases(input vram_bases_t exp, input vram_bases_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: VRAM bases expected %h got %h",
                                $time, exp, act));
        end
    endtask

    task automatic check_scroll(input scroll_pos_t exp, input scroll_pos_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: scroll words expected %h got %h",
                                $time, exp, act));
        end
    endtask

    task automatic check_layer(input layer_cfg_t exp, input layer_cfg_t act, input bit masks_on);
        layer_cfg_t e;
        layer_cfg_t a;
        e = exp;
        a = act;
        // masks only mean something once the chain is full
        if (!masks_on) begin
            {e.mask0, e.mask1, e.mask2, e.mask3, e.mask4} = '0;
            {a.mask0, a.mask1, a.mask2, a.mask3, a.mask4} = '0;
        end
        if (a !== e) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: layer config expected %h got %h",
                                $time, e, a));
        end
    endtask

    function automatic vram_bases_t expected_bases();
        return '{obj_base: a_model[A_OBJ_BASE], scr1_base: a_model[A_SCR1_BASE],
                 scr2_base: a_model[A_SCR2_BASE], scr3_base: a_model[A_SCR3_BASE],
                 row_base: a_model[A_ROW_BASE], star_base: a_model[A_STAR_BASE],
                 pal_base: a_model[A_PAL_BASE]};
    endfunction

    function automatic scroll_pos_t expected_scroll();
        return '{hpos1: a_model[A_HPOS1], hpos2: a_model[A_HPOS2], hpos3: a_model[A_HPOS3],
                 vpos1: a_model[A_VPOS1], vpos2: a_model[A_VPOS2], vpos3: a_model[A_VPOS3],
                 hstar1: a_model[A_HSTAR1], vstar1: a_model[A_VSTAR1],
                 hstar2: a_model[A_HSTAR2], vstar2: a_model[A_VSTAR2],
                 ppu_ctrl: a_model[A_PPU_CTRL]};
    endfunction

    function automatic layer_cfg_t expected_layer();
        return '{layer_ctrl: layer_m, prio0: prio_m[0], prio1: prio_m[1],
                 prio2: prio_m[2], prio3: prio_m[3], pal_page_en: pal_page_m,
                 mask0: chain_model[CFG_MASK0], mask1: chain_model[CFG_MASK1],
                 mask2: chain_model[CFG_MASK2], mask3: chain_model[CFG_MASK3],
                 mask4: chain_model[CFG_MASK3]};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[14:0], lfsr_state[0]};
        end
    endtask

    task automatic model_write(input logic [5:0] adr, input logic [1:0] sel,
                               input logic [15:0] data);
        logic [4:0] w;
        w = adr[4:0];
        if (!adr[5]) begin
            if (w < 5'(CPSA_NREGS)) begin
                if (sel[0]) begin
                    a_model[w][7:0] = data[7:0];
                end
                if (sel[1]) begin
                    a_model[w][15:8] = data[15:8];
                end
            end
        end else if (sel == 2'b11) begin
            // CPS-B map holds byte addresses
            if (w == chain_model[CFG_LAYER][5:1]) begin
                layer_m = data;
            end
            for (int i = 0; i < 4; i++) begin
                if (w == chain_model[CFG_PRIO0 + i][5:1]) begin
                    prio_m[i] = data;
                end
            end
            if (w == chain_model[CFG_PAL_PAGE][5:1]) begin
                pal_page_m = data[5:0];
            end
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [5:0] adr, input logic [1:0] sel,
                             input logic [15:0] data, output logic [15:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_sel = sel;
        wb_dat_w = data;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 20);
        if (!wb_ack) begin
            abort_run($sformatf("no ack from the DUT within 20 cycles at address %h", adr));
        end
        check_count(1, waited, "ack latency in cycles");
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        // the copy pulse is due on the first edge after the strobe falls
        if (we && adr == {1'b0, A_PAL_BASE}) begin
            pal_drop_cycle = cycle_no;
        end
    endtask

    task automatic shift_config(input logic [7:0] b);
        @(negedge clk);
        cfg_we = 1'b1;
        cfg_data = b;
        for (int i = CFG_BYTES - 1; i > 0; i--) begin
            chain_model[i] = chain_model[i - 1];
        end
        chain_model[0] = b;
        cfg_count++;
    endtask

    task automatic require_fields(input int got, input int want);
        if (got != want) begin
            abort_run("malformed line in the vector file");
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          ch;
        int          first;
        int          last;
        int          pulses;
        int          pulse_mark;
        logic [7:0]  op;
        logic [5:0]  adr;
        logic [1:0]  sel;
        logic [15:0] data;
        logic [15:0] rdata;
        logic [15:0] rnd_sel;
        logic [15:0] rnd_data;
        logic [7:0]  cfg_byte;

        clk = 1'b0;
        reg_rst = 1'b1;
        ppu_rstn = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_sel = '0;
        wb_dat_w = '0;
        cfg_we = 1'b0;
        cfg_data = '0;
        lfsr_state = 32'h68d5_df9a;
        pulse_mark = 0;
        cfg_count = 0;
        for (int i = 0; i < CPSA_NREGS; i++) begin
            a_model[i] = '0;
        end
        for (int i = 0; i < CFG_BYTES; i++) begin
            chain_model[i] = '0;
        end
        layer_m = LAYER_CTRL_RST;
        for (int i = 0; i < 4; i++) begin
            prio_m[i] = PRIO_RST;
        end
        pal_page_m = PAL_PAGE_RST;

        repeat (10) @(negedge clk);
        reg_rst = 1'b0;

        fd = $fopen("verif/cps_mmr_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verif/cps_mmr_vectors.txt");
        end
        while ($fscanf(fd, "%s", op) == 1) begin
            case (op)
                "#": begin
                    // skip the rest of the line up to the newline (10)
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "c": begin
                    for (int i = 0; i < CFG_BYTES; i++) begin
                        n = $fscanf(fd, "%h", cfg_byte);
                        require_fields(n, 1);
                        shift_config(cfg_byte);
                    end
                    @(negedge clk);
                    cfg_we = 1'b0;
                end
                "w": begin
                    n = $fscanf(fd, "%h %h %h", adr, sel, data);
                    require_fields(n, 3);
                    bus_cycle(1'b1, adr, sel, data, rdata);
                    model_write(adr, sel, data);
                end
                "r": begin
                    n = $fscanf(fd, "%h %h", adr, data);
                    require_fields(n, 2);
                    bus_cycle(1'b0, adr, 2'b11, 16'h0000, rdata);
                    check_word(data, rdata, $sformatf("read at address %h", adr));
                end
                "x": begin
                    n = $fscanf(fd, "%h %h", first, last);
                    require_fields(n, 2);
                    for (int w = first; w <= last; w++) begin
                        random_bits(2, rnd_sel);
                        random_bits(16, rnd_data);
                        bus_cycle(1'b1, 6'(w), rnd_sel[1:0], rnd_data, rdata);
                        model_write(6'(w), rnd_sel[1:0], rnd_data);
                    end
                end
                "p": begin
                    n = $fscanf(fd, "%h", pulses);
                    require_fields(n, 1);
                    // the pulse follows the write by two edges at most
                    repeat (3) @(negedge clk);
                    check_count(pulses, pulse_count - pulse_mark, "pal_copy high cycles");
                    if (pulses != 0) begin
                        check_count(pal_drop_cycle + 1, pulse_cycle, "pal_copy start cycle");
                    end
                    pulse_mark = pulse_count;
                end
                "b": check_bases(expected_bases(), bases);
                "s": check_scroll(expected_scroll(), scroll);
                "l": check_layer(expected_layer(), layer, cfg_count >= CFG_BYTES);
                default: begin
                    abort_run($sformatf("unknown operation %c in the vector file", op));
                end
            endcase
        end
        $fclose(fd);

        if (u_cps_mmr_top.u_mmr_asserts.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("assertion failures were reported during the run");
        end
    end

endmodule

// File: verif/cps_mmr_asserts.sv
/*
 * Concurrent checks on the Wishbone handshake and the
 * palette copy pulse, bound into the register block top level.
 */
`timescale 1ns/1ps

module cps_mmr_asserts (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic pal_copy
);

    int unsigned fail_count = 0;

    // ack is a single-cycle strobe
    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack high for two cycles in a row");
        end

    // every ack answers a strobe taken on the edge before
    ack_after_stb: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
        else begin
            fail_count++;
            $error("wb_ack without an accepted strobe one cycle before");
        end

    pal_single: assert property (@(posedge clk) disable iff (rst) pal_copy |=> !pal_copy)
        else begin
            fail_count++;
            $error("pal_copy high for more than one cycle");
        end

endmodule

bind cps_mmr_top cps_mmr_asserts u_mmr_asserts (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .pal_copy (pal_copy)
);

// File: verilog/cps_mmr_top.sv
/*
 * Register block top level: Wishbone port, CPS-A bank,
 * CPS-B configuration chain and CPS-B bank.
 */
`timescale 1ns/1ps

module cps_mmr_top import cps_mmr_pkg::*; (
    input  logic        clk,
    input  logic        reg_rst,
    input  logic        ppu_rstn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [6:1]  wb_adr,
    input  logic [1:0]  wb_sel,
    input  logic [15:0] wb_dat_w,
    output logic [15:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        cfg_we,
    input  logic [7:0]  cfg_data,
    output vram_bases_t bases,
    output scroll_pos_t scroll,
    output layer_cfg_t  layer,
    output logic        pal_copy
);

    logic            rst;
    cps_bus_t        bus;
    cpsb_map_t       map;
    logic [3:0][7:0] masks;
    logic [15:0]     rd_data;

    // either the system or the PPU can hold the block in reset
    assign rst = reg_rst | ~ppu_rstn;

    wb_ppu_port u_wb_ppu_port (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .rd_data  (rd_data),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .bus      (bus)
    );

    cpsa_regs u_cpsa_regs (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .bases    (bases),
        .scroll   (scroll),
        .pal_copy (pal_copy)
    );

    cpsb_cfg_chain u_cpsb_cfg_chain (
        .clk      (clk),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .map      (map),
        .masks    (masks)
    );

    cpsb_regs u_cpsb_regs (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .map      (map),
        .masks    (masks),
        .layer    (layer),
        .rd_data  (rd_data)
    );

endmodule

// File: verilog/cpsb_regs.sv
/*
 * CPS-B register bank: address match against the configured map,
 * word-only writes, the 16x16 multiplier and the read multiplexer.
 */
`timescale 1ns/1ps

module cpsb_regs import cps_mmr_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  cps_bus_t        bus,
    input  cpsb_map_t       map,
    input  logic [3:0][7:0] masks,
    output layer_cfg_t      layer,
    output logic [15:0]     rd_data
);

    logic        wr;
    logic [15:0] mult1;
    logic [15:0] mult2;
    logic [31:0] product;
    logic [15:0] layer_ctrl;
    logic [15:0] prio0;
    logic [15:0] prio1;
    logic [15:0] prio2;
    logic [15:0] prio3;
    logic [5:0]  pal_page_en;

    // both byte lanes are needed, the chip takes whole words only
    assign wr = bus.b_sel & bus.we & (&bus.be);

    // multiplier operands
    always_ff @(posedge clk) begin
        if (wr && bus.addr == map.mult1_addr) begin
            mult1 <= bus.wdata;
        end
        if (wr && bus.addr == map.mult2_addr) begin
            mult2 <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        product <= mult1 * mult2;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            layer_ctrl  <= LAYER_CTRL_RST;
            prio0       <= PRIO_RST;
            prio1       <= PRIO_RST;
            prio2       <= PRIO_RST;
            prio3       <= PRIO_RST;
            pal_page_en <= PAL_PAGE_RST;
        end else if (wr) begin
            if (bus.addr == map.layer_addr) layer_ctrl <= bus.wdata;
            if (bus.addr == map.prio0_addr) prio0 <= bus.wdata;
            if (bus.addr == map.prio1_addr) prio1 <= bus.wdata;
            if (bus.addr == map.prio2_addr) prio2 <= bus.wdata;
            if (bus.addr == map.prio3_addr) prio3 <= bus.wdata;
            if (bus.addr == map.pal_page_addr) pal_page_en <= bus.wdata[5:0];
        end
    end

    // priority follows the chain order, lowest index first
    always_comb begin
        if (&bus.addr) begin
            rd_data = OPEN_BUS;
        end else if (bus.addr == map.id_addr) begin
            // ID is stored compressed, one nibble per byte
            rd_data = {4'd0, map.id_val[7:4], 4'd0, map.id_val[3:0]};
        end else if (bus.addr == map.mult1_addr) begin
            rd_data = mult1;
        end else if (bus.addr == map.mult2_addr) begin
            rd_data = mult2;
        end else if (bus.addr == map.rslt0_addr) begin
            rd_data = product[15:0];
        end else if (bus.addr == map.rslt1_addr) begin
            rd_data = product[31:16];
        end else if (bus.addr == map.layer_addr) begin
            rd_data = layer_ctrl;
        end else if (bus.addr == map.prio0_addr) begin
            rd_data = prio0;
        end else if (bus.addr == map.prio1_addr) begin
            rd_data = prio1;
        end else if (bus.addr == map.prio2_addr) begin
            rd_data = prio2;
        end else if (bus.addr == map.prio3_addr) begin
            rd_data = prio3;
        end else if (bus.addr == map.pal_page_addr) begin
            rd_data = {10'd0, pal_page_en};
        end else begin
            rd_data = OPEN_BUS;
        end
    end

    // layer 4 has no mask of its own and reuses mask 3
    assign layer = '{
        layer_ctrl:  layer_ctrl,
        prio0:       prio0,
        prio1:       prio1,
        prio2:       prio2,
        prio3:       prio3,
        pal_page_en: pal_page_en,
        mask0:       masks[0],
        mask1:       masks[1],
        mask2:       masks[2],
        mask3:       masks[3],
        mask4:       masks[3]
    };

endmodule

// File: verilog/cpsb_cfg_chain.sv
/*
 * CPS-B configuration chain: a byte-wide shift register that
 * holds the game's CPS-B register addresses, ID and layer masks.
 */
`timescale 1ns/1ps

module cpsb_cfg_chain import cps_mmr_pkg::*; (
    input  logic            clk,
    input  logic            cfg_we,
    input  logic [7:0]      cfg_data,
    output cpsb_map_t       map,
    output logic [3:0][7:0] masks
);

    logic [CFG_BYTES-1:0][7:0] chain;

    // first byte in travels up to the top index
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            chain <= {chain[CFG_BYTES-2:0], cfg_data};
        end
    end

    // stored as byte addresses, the bus works in words
    assign map = '{
        id_addr:       chain[CFG_ID_ADDR][5:1],
        mult1_addr:    chain[CFG_MULT1][5:1],
        mult2_addr:    chain[CFG_MULT2][5:1],
        rslt0_addr:    chain[CFG_RSLT0][5:1],
        rslt1_addr:    chain[CFG_RSLT1][5:1],
        layer_addr:    chain[CFG_LAYER][5:1],
        prio0_addr:    chain[CFG_PRIO0][5:1],
        prio1_addr:    chain[CFG_PRIO1][5:1],
        prio2_addr:    chain[CFG_PRIO2][5:1],
        prio3_addr:    chain[CFG_PRIO3][5:1],
        pal_page_addr: chain[CFG_PAL_PAGE][5:1],
        id_val:        chain[CFG_ID_VAL]
    };

    assign masks = {chain[CFG_MASK3], chain[CFG_MASK2], chain[CFG_MASK1], chain[CFG_MASK0]};

endmodule

// File: verilog/cpsa_regs.sv
/*
 * CPS-A register bank: eighteen fixed 16-bit registers with
 * byte-lane writes, and the one-cycle palette copy pulse.
 */
`timescale 1ns/1ps

module cpsa_regs import cps_mmr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cps_bus_t    bus,
    output vram_bases_t bases,
    output scroll_pos_t scroll,
    output logic        pal_copy
);

    logic [15:0] regs [CPSA_NREGS];
    logic        wr;
    logic        pal_pend;

    // keep the old byte where its enable is low
    function automatic logic [15:0] lane_merge(
        input logic [15:0] old_val,
        input logic [15:0] new_val,
        input logic [1:0]  be
    );
        lane_merge = {be[1] ? new_val[15:8] : old_val[15:8],
                      be[0] ? new_val[7:0]  : old_val[7:0]};
    endfunction

    assign wr = bus.a_sel & bus.we;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < CPSA_NREGS; i++) begin
                regs[i] <= 16'd0;
            end
        end else if (wr && bus.addr < 5'(CPSA_NREGS)) begin
            regs[bus.addr] <= lane_merge(regs[bus.addr], bus.wdata, bus.be);
        end
    end

    // the copy waits until the CPU has left the window, so the
    // palette base is stable when the copy engine samples it
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pal_pend <= 1'b0;
            pal_copy <= 1'b0;
        end else begin
            pal_copy <= pal_pend & ~bus.a_sel;
            if (pal_pend && !bus.a_sel) begin
                pal_pend <= 1'b0;
            end
            if (wr && bus.addr == A_PAL_BASE) begin
                pal_pend <= 1'b1;
            end
        end
    end

    assign bases = '{
        obj_base:  regs[A_OBJ_BASE],
        scr1_base: regs[A_SCR1_BASE],
        scr2_base: regs[A_SCR2_BASE],
        scr3_base: regs[A_SCR3_BASE],
        row_base:  regs[A_ROW_BASE],
        star_base: regs[A_STAR_BASE],
        pal_base:  regs[A_PAL_BASE]
    };

    assign scroll = '{
        hpos1:    regs[A_HPOS1],
        hpos2:    regs[A_HPOS2],
        hpos3:    regs[A_HPOS3],
        vpos1:    regs[A_VPOS1],
        vpos2:    regs[A_VPOS2],
        vpos3:    regs[A_VPOS3],
        hstar1:   regs[A_HSTAR1],
        vstar1:   regs[A_VSTAR1],
        hstar2:   regs[A_HSTAR2],
        vstar2:   regs[A_VSTAR2],
        ppu_ctrl: regs[A_PPU_CTRL]
    };

endmodule

// File: verilog/wb_ppu_port.sv
/*
 * Wishbone classic slave for the register block.
 * Splits accepted cycles into the CPS-A and CPS-B windows,
 * registers ack and returns the read word.
 */
`timescale 1ns/1ps

module wb_ppu_port import cps_mmr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [6:1]  wb_adr,
    input  logic [1:0]  wb_sel,
    input  logic [15:0] wb_dat_w,
    input  logic [15:0] rd_data,
    output logic        wb_ack,
    output logic [15:0] wb_dat_r,
    output cps_bus_t    bus
);

    logic accept;

    // a cycle is taken only while ack is low, so ack never repeats
    assign accept = wb_cyc & wb_stb & ~wb_ack;

    assign bus = '{
        addr:  wb_adr[5:1],
        be:    wb_sel,
        wdata: wb_dat_w,
        we:    wb_we,
        a_sel: accept & ~wb_adr[6],
        b_sel: accept & wb_adr[6]
    };

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= accept;
        end
    end

    // read word is sampled on the acking edge
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_dat_r <= OPEN_BUS;
        end else if (accept && !wb_we) begin
            if (wb_adr[6]) begin
                wb_dat_r <= rd_data;
            end else begin
                // CPS-A is write only
                wb_dat_r <= OPEN_BUS;
            end
        end
    end

endmodule

// File: verilog/cps_mmr_pkg.sv
/*
 * Shared definitions for the CPS-A / CPS-B register block:
 * sizes, CPS-A word offsets, configuration chain byte indices,
 * reset values and the packed structs passed between modules.
 */
package cps_mmr_pkg;

    localparam int CFG_BYTES  = 16;
    localparam int CPSA_NREGS = 18;

    // CPS-A word offsets
    localparam logic [4:0] A_OBJ_BASE  = 5'd0;
    localparam logic [4:0] A_SCR1_BASE = 5'd1;
    localparam logic [4:0] A_SCR2_BASE = 5'd2;
    localparam logic [4:0] A_SCR3_BASE = 5'd3;
    localparam logic [4:0] A_ROW_BASE  = 5'd4;
    localparam logic [4:0] A_PAL_BASE  = 5'd5;
    localparam logic [4:0] A_HPOS1     = 5'd6;
    localparam logic [4:0] A_VPOS1     = 5'd7;
    localparam logic [4:0] A_HPOS2     = 5'd8;
    localparam logic [4:0] A_VPOS2     = 5'd9;
    localparam logic [4:0] A_HPOS3     = 5'd10;
    localparam logic [4:0] A_VPOS3     = 5'd11;
    localparam logic [4:0] A_HSTAR1    = 5'd12;
    localparam logic [4:0] A_VSTAR1    = 5'd13;
    localparam logic [4:0] A_HSTAR2    = 5'd14;
    localparam logic [4:0] A_VSTAR2    = 5'd15;
    localparam logic [4:0] A_STAR_BASE = 5'd16;
    localparam logic [4:0] A_PPU_CTRL  = 5'd17;

    // byte positions inside the configuration chain
    localparam int CFG_ID_ADDR  = 0;
    localparam int CFG_ID_VAL   = 1;
    localparam int CFG_MULT1    = 2;
    localparam int CFG_MULT2    = 3;
    localparam int CFG_RSLT0    = 4;
    localparam int CFG_RSLT1    = 5;
    localparam int CFG_LAYER    = 6;
    localparam int CFG_PRIO0    = 7;
    localparam int CFG_PRIO1    = 8;
    localparam int CFG_PRIO2    = 9;
    localparam int CFG_PRIO3    = 10;
    localparam int CFG_PAL_PAGE = 11;
    localparam int CFG_MASK0    = 12;
    localparam int CFG_MASK1    = 13;
    localparam int CFG_MASK2    = 14;
    localparam int CFG_MASK3    = 15;

    // default layer order 3,2,1,0
    localparam logic [15:0] LAYER_CTRL_RST = {3'b0, 2'b11, 2'b10, 2'b01, 2'b00, 5'd0};
    localparam logic [15:0] PRIO_RST       = 16'hffff;
    localparam logic [5:0]  PAL_PAGE_RST   = 6'h3f;
    localparam logic [15:0] OPEN_BUS       = 16'hffff;

    typedef struct packed {
        logic [4:0]  addr;
        logic [1:0]  be;
        logic [15:0] wdata;
        logic        we;
        logic        a_sel;
        logic        b_sel;
    } cps_bus_t;

    typedef struct packed {
        logic [15:0] obj_base;
        logic [15:0] scr1_base;
        logic [15:0] scr2_base;
        logic [15:0] scr3_base;
        logic [15:0] row_base;
        logic [15:0] star_base;
        logic [15:0] pal_base;
    } vram_bases_t;

    typedef struct packed {
        logic [15:0] hpos1;
        logic [15:0] hpos2;
        logic [15:0] hpos3;
        logic [15:0] vpos1;
        logic [15:0] vpos2;
        logic [15:0] vpos3;
        logic [15:0] hstar1;
        logic [15:0] vstar1;
        logic [15:0] hstar2;
        logic [15:0] vstar2;
        logic [15:0] ppu_ctrl;
    } scroll_pos_t;

    typedef struct packed {
        logic [4:0] id_addr;
        logic [4:0] mult1_addr;
        logic [4:0] mult2_addr;
        logic [4:0] rslt0_addr;
        logic [4:0] rslt1_addr;
        logic [4:0] layer_addr;
        logic [4:0] prio0_addr;
        logic [4:0] prio1_addr;
        logic [4:0] prio2_addr;
        logic [4:0] prio3_addr;
        logic [4:0] pal_page_addr;
        logic [7:0] id_val;
    } cpsb_map_t;

    typedef struct packed {
        logic [15:0] layer_ctrl;
        logic [15:0] prio0;
        logic [15:0] prio1;
        logic [15:0] prio2;
        logic [15:0] prio3;
        logic [5:0]  pal_page_en;
        logic [7:0]  mask0;
        logic [7:0]  mask1;
        logic [7:0]  mask2;
        logic [7:0]  mask3;
        logic [7:0]  mask4;
    } layer_cfg_t;

endpackage
